/* files.f */
+incdir+logic
+incdir+tb
logic/dp_ops_pkg.sv
logic/dp_flags_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/status_flags.sv
logic/pc_unit.sv
logic/dp_top.sv
tb/tb_dp_top.sv

/* run_sim.sh */
#!/bin/sh
# builds the datapath testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_dp_top -o sim_dp_top > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_dp_top > sim.log 2>&1 || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log

grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "no final result in sim.log"; exit 1; }
echo "simulation passed"

/* tb/dp_ref_model.svh */
// reference model of registers, flags, pc and result, included inside the testbench module
// also holds the LCG that feeds the random stimulus

`ifndef DP_REF_MODEL_SVH
`define DP_REF_MODEL_SVH

`include "dp_defines.svh"

logic [31:0] lcg_state;
dp_ops_pkg::data_t m_regs [`DP_REG_COUNT];
dp_flags_pkg::status_t m_status;
dp_ops_pkg::pc_t m_pc;
dp_ops_pkg::data_t m_result;

function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

task automatic model_reset();
  for (int i = 0; i < `DP_REG_COUNT; i++) begin
    m_regs[i] = '0;
  end
  m_status = '0;
  m_pc = '0;
  m_result = '0;
endtask

// one valid op; effects match what the DUT shows after the next edge
task automatic model_apply(
  input dp_ops_pkg::alu_op_t     op,
  input dp_ops_pkg::reg_addr_t   sa,
  input dp_ops_pkg::reg_addr_t   sb,
  input dp_ops_pkg::reg_addr_t   d,
  input logic                    ui,
  input dp_ops_pkg::data_t       im,
  input dp_flags_pkg::flag_idx_t cs,
  input logic                    cp
);
  dp_ops_pkg::data_t bv;
  dp_ops_pkg::data_t res;
  int a;
  int b;
  int c;
  int full;
  int sgn;
  logic cout;
  logic nz_upd;
  logic c_upd;
  logic v_upd;
  logic taken;
  bv = ui ? im : m_regs[sb];
  a = int'(m_regs[sa]);
  b = int'(bv);
  c = m_status[dp_flags_pkg::FLAG_C] ? 1 : 0;
  sgn = 0;
  cout = 1'b0;
  res = m_regs[sa];
  nz_upd = 1'b1;
  c_upd = 1'b0;
  v_upd = 1'b0;
  case (op)
    dp_ops_pkg::ADC: begin
      full = a + b + c;
      sgn = int'($signed(m_regs[sa])) + int'($signed(bv)) + c;
      res = dp_ops_pkg::data_t'(full);
      cout = (full > 255);
      c_upd = 1'b1;
      v_upd = 1'b1;
    end
    dp_ops_pkg::SBC, dp_ops_pkg::CMP: begin
      // compare always subtracts without borrow
      if (op == dp_ops_pkg::CMP) c = 1;
      full = a - b - (1 - c);
      sgn = int'($signed(m_regs[sa])) - int'($signed(bv)) - (1 - c);
      res = dp_ops_pkg::data_t'(full);
      cout = (full >= 0);
      c_upd = 1'b1;
      v_upd = 1'b1;
    end
    dp_ops_pkg::AND: res = m_regs[sa] & bv;
    dp_ops_pkg::ORA: res = m_regs[sa] | bv;
    dp_ops_pkg::EOR: res = m_regs[sa] ^ bv;
    dp_ops_pkg::INC: res = dp_ops_pkg::data_t'(a + 1);
    dp_ops_pkg::DEC: res = dp_ops_pkg::data_t'(a - 1);
    dp_ops_pkg::MOV: res = bv;
    dp_ops_pkg::ASL, dp_ops_pkg::ROL: begin
      res = dp_ops_pkg::data_t'(a * 2 + ((op == dp_ops_pkg::ROL) ? c : 0));
      cout = (a >= 128);
      c_upd = 1'b1;
    end
    dp_ops_pkg::LSR, dp_ops_pkg::ROR: begin
      res = dp_ops_pkg::data_t'(a / 2 + ((op == dp_ops_pkg::ROR) ? c * 128 : 0));
      cout = (a % 2 == 1);
      c_upd = 1'b1;
    end
    dp_ops_pkg::CLC, dp_ops_pkg::SEC: begin
      nz_upd = 1'b0;
      c_upd = 1'b1;
      cout = (op == dp_ops_pkg::SEC);
    end
    default: nz_upd = 1'b0;
  endcase
  taken = (op == dp_ops_pkg::BRA) && (m_status[cs] ^ cp);
  m_pc = dp_ops_pkg::pc_t'(int'(m_pc) + 1 + (taken ? int'($signed(im)) : 0));
  if (nz_upd) begin
    m_status[dp_flags_pkg::FLAG_N] = res[`DP_DATA_WIDTH-1];
    m_status[dp_flags_pkg::FLAG_Z] = (res == '0);
  end
  if (c_upd) m_status[dp_flags_pkg::FLAG_C] = cout;
  if (v_upd) m_status[dp_flags_pkg::FLAG_V] = (sgn > 127) || (sgn < -128);
  if (!(op inside {dp_ops_pkg::CMP, dp_ops_pkg::CLC, dp_ops_pkg::SEC, dp_ops_pkg::BRA})) begin
    m_regs[d] = res;
  end
  m_result = res;
endtask

`endif

/* tb/tb_dp_top.sv */
// random and directed micro-ops against the reference model in dp_ref_model.svh
// outputs are sampled 1 ns after each rising edge, inputs change 5 ns after it

`timescale 1ns/1ps

`include "dp_defines.svh"

module tb_dp_top;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 3;
  localparam int DIRECTED_OPS = 48;
  localparam int RANDOM_OPS = 2000;
  localparam logic [31:0] SEED = 32'd86479;

  logic clk;
  logic reset;
  logic op_valid;
  dp_ops_pkg::alu_op_t alu_op;
  dp_ops_pkg::reg_addr_t src_a;
  dp_ops_pkg::reg_addr_t src_b;
  dp_ops_pkg::reg_addr_t dst;
  logic use_imm;
  dp_ops_pkg::data_t imm;
  dp_flags_pkg::flag_idx_t cond_sel;
  logic cond_polarity;
  dp_ops_pkg::data_t result;
  dp_flags_pkg::status_t status;
  dp_ops_pkg::pc_t pc;

  int checks;
  int errors;

  `include "dp_ref_model.svh"

  dp_top uut (
    .clk           (clk),
    .reset         (reset),
    .op_valid      (op_valid),
    .alu_op        (alu_op),
    .src_a         (src_a),
    .src_b         (src_b),
    .dst           (dst),
    .use_imm       (use_imm),
    .imm           (imm),
    .cond_sel      (cond_sel),
    .cond_polarity (cond_polarity),
    .result        (result),
    .status        (status),
    .pc            (pc)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_outputs();
    checks++;
    assert (result === m_result) else begin
      $display("MISMATCH time=%0t signal=result expected=%h actual=%h", $time, m_result, result);
      errors++;
    end
    assert (status === m_status) else begin
      $display("MISMATCH time=%0t signal=status expected=%b actual=%b", $time, m_status, status);
      errors++;
    end
    assert (pc === m_pc) else begin
      $display("MISMATCH time=%0t signal=pc expected=%h actual=%h", $time, m_pc, pc);
      errors++;
    end
  endtask

  // wait for the edge, check just after it, return 5 ns past the edge
  task automatic advance();
    @(posedge clk);
    #1;
    check_outputs();
    #4;
  endtask

  task automatic issue(
    input dp_ops_pkg::alu_op_t     op,
    input dp_ops_pkg::reg_addr_t   sa,
    input dp_ops_pkg::reg_addr_t   sb,
    input dp_ops_pkg::reg_addr_t   d,
    input logic                    ui,
    input dp_ops_pkg::data_t       im,
    input dp_flags_pkg::flag_idx_t cs,
    input logic                    cp
  );
    op_valid = 1'b1;
    alu_op = op;
    src_a = sa;
    src_b = sb;
    dst = d;
    use_imm = ui;
    imm = im;
    cond_sel = cs;
    cond_polarity = cp;
    model_apply(op, sa, sb, d, ui, im, cs, cp);
    advance();
  endtask

  task automatic alu_with_imm(input dp_ops_pkg::alu_op_t op, input int d, input int sa,
                              input dp_ops_pkg::data_t im);
    issue(op, 2'(sa), 2'd0, 2'(d), 1'b1, im, dp_flags_pkg::FLAG_C, 1'b0);
  endtask

  task automatic alu_with_reg(input dp_ops_pkg::alu_op_t op, input int d, input int sa,
                              input int sb);
    issue(op, 2'(sa), 2'(sb), 2'(d), 1'b0, 8'h00, dp_flags_pkg::FLAG_C, 1'b0);
  endtask

  task automatic branch_on(input dp_flags_pkg::flag_idx_t cs, input logic cp,
                           input dp_ops_pkg::data_t im);
    issue(dp_ops_pkg::BRA, 2'd0, 2'd0, 2'd0, 1'b1, im, cs, cp);
  endtask

  // random garbage on every input while op_valid stays low
  task automatic issue_idle(input logic [31:0] r);
    op_valid = 1'b0;
    alu_op = dp_ops_pkg::alu_op_t'(r[27:24]);
    src_a = r[23:22];
    src_b = r[21:20];
    dst = r[19:18];
    use_imm = r[17];
    imm = r[15:8];
    cond_sel = dp_flags_pkg::flag_idx_t'(r[7:6]);
    cond_polarity = r[5];
    advance();
  endtask

  task automatic issue_random();
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = next_random();
    r2 = next_random();
    if (r1[31:29] == 3'd0) begin
      issue_idle(r2);
    end else begin
      issue(dp_ops_pkg::alu_op_t'(r1[27:24]), r1[23:22], r1[21:20], r1[19:18], r1[17],
            r2[31:24], dp_flags_pkg::flag_idx_t'(r2[23:22]), r2[21]);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  initial begin
    int base;
    clk = 1'b0;
    reset = 1'b1;
    op_valid = 1'b0;
    alu_op = dp_ops_pkg::ADC;
    src_a = '0;
    src_b = '0;
    dst = '0;
    use_imm = 1'b0;
    imm = '0;
    cond_sel = dp_flags_pkg::FLAG_C;
    cond_polarity = 1'b0;
    checks = 0;
    errors = 0;
    lcg_state = SEED;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    reset = 1'b0;

    base = errors;
    check_outputs();
    alu_with_imm(dp_ops_pkg::MOV, 0, 0, 8'h00);
    assert (pc === 16'd1) else begin
      $display("MISMATCH time=%0t signal=pc expected=%h actual=%h", $time, 16'd1, pc);
      errors++;
    end
    report_test("reset", base);

    // signed overflow corners, then compares and register read-back
    base = errors;
    alu_with_imm(dp_ops_pkg::CLC, 0, 0, 8'h00);
    alu_with_imm(dp_ops_pkg::MOV, 0, 0, 8'h7f);
    alu_with_imm(dp_ops_pkg::MOV, 1, 0, 8'h01);
    alu_with_reg(dp_ops_pkg::ADC, 2, 0, 1);
    alu_with_imm(dp_ops_pkg::MOV, 0, 0, 8'h80);
    alu_with_imm(dp_ops_pkg::SEC, 0, 0, 8'h00);
    alu_with_imm(dp_ops_pkg::SBC, 3, 0, 8'h01);
    alu_with_imm(dp_ops_pkg::CMP, 3, 3, 8'h7f);
    alu_with_reg(dp_ops_pkg::CMP, 1, 2, 3);
    alu_with_reg(dp_ops_pkg::MOV, 1, 0, 3);
    alu_with_reg(dp_ops_pkg::ADC, 0, 1, 2);
    alu_with_reg(dp_ops_pkg::SBC, 2, 2, 2);
    report_test("arithmetic", base);

    base = errors;
    alu_with_imm(dp_ops_pkg::AND, 0, 1, 8'hf0);
    alu_with_imm(dp_ops_pkg::ORA, 1, 0, 8'h81);
    alu_with_reg(dp_ops_pkg::EOR, 2, 1, 1);
    alu_with_imm(dp_ops_pkg::INC, 3, 1, 8'h00);
    alu_with_imm(dp_ops_pkg::DEC, 2, 2, 8'h00);
    alu_with_imm(dp_ops_pkg::ASL, 0, 1, 8'h00);
    alu_with_imm(dp_ops_pkg::LSR, 0, 1, 8'h00);
    alu_with_imm(dp_ops_pkg::SEC, 0, 0, 8'h00);
    alu_with_imm(dp_ops_pkg::ROL, 1, 0, 8'h00);
    alu_with_imm(dp_ops_pkg::ROR, 2, 1, 8'h00);
    alu_with_imm(dp_ops_pkg::CLC, 0, 0, 8'h00);
    alu_with_imm(dp_ops_pkg::ROR, 3, 2, 8'h00);
    report_test("logic_shift", base);

    // pc is small here, so a backward jump wraps below zero
    base = errors;
    alu_with_imm(dp_ops_pkg::SEC, 0, 0, 8'h00);
    branch_on(dp_flags_pkg::FLAG_C, 1'b0, 8'h80);
    branch_on(dp_flags_pkg::FLAG_C, 1'b1, 8'h10);
    alu_with_imm(dp_ops_pkg::CLC, 0, 0, 8'h00);
    branch_on(dp_flags_pkg::FLAG_C, 1'b1, 8'h7f);
    branch_on(dp_flags_pkg::FLAG_Z, 1'b0, 8'hf0);
    branch_on(dp_flags_pkg::FLAG_N, 1'b1, 8'h05);
    report_test("branch", base);

    base = errors;
    repeat (8) issue_idle(next_random());
    report_test("idle", base);

    base = errors;
    repeat (RANDOM_OPS) issue_random();
    report_test("random", base);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #((RESET_CYCLES + DIRECTED_OPS + RANDOM_OPS + 20) * CLK_PERIOD);
    $display("timeout: the run did not finish in the expected time");
    $display("Done: errors found");
    $finish;
  end

endmodule

/* logic/dp_top.sv */
// single-cycle datapath slice: register file, ALU, status flags and pc
// one micro-op per cycle while op_valid is high, no back-pressure
// every effect of an op is visible right after the next rising edge

`timescale 1ns/1ps

module dp_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    op_valid,
  input  dp_ops_pkg::alu_op_t     alu_op,
  input  dp_ops_pkg::reg_addr_t   src_a,
  input  dp_ops_pkg::reg_addr_t   src_b,
  input  dp_ops_pkg::reg_addr_t   dst,
  input  logic                    use_imm,
  input  dp_ops_pkg::data_t       imm,
  input  dp_flags_pkg::flag_idx_t cond_sel,
  input  logic                    cond_polarity,
  output dp_ops_pkg::data_t       result,
  output dp_flags_pkg::status_t   status,
  output dp_ops_pkg::pc_t         pc
);

  dp_ops_pkg::data_t read_data_a;
  dp_ops_pkg::data_t read_data_b;
  dp_ops_pkg::data_t alu_result;
  logic carry_out;
  logic overflow;
  logic writes_reg;
  logic branch_taken;

  reg_file u_reg_file (
    .clk          (clk),
    .reset        (reset),
    .write_enable (op_valid & writes_reg),
    .write_addr   (dst),
    .write_data   (alu_result),
    .read_addr_a  (src_a),
    .read_addr_b  (src_b),
    .read_data_a  (read_data_a),
    .read_data_b  (read_data_b)
  );

  alu u_alu (
    .alu_op     (alu_op),
    .a          (read_data_a),
    .reg_b      (read_data_b),
    .imm        (imm),
    .use_imm    (use_imm),
    .carry_in   (status[dp_flags_pkg::FLAG_C]),
    .result     (alu_result),
    .carry_out  (carry_out),
    .overflow   (overflow),
    .writes_reg (writes_reg)
  );

  status_flags u_status_flags (
    .clk           (clk),
    .reset         (reset),
    .op_valid      (op_valid),
    .alu_op        (alu_op),
    .result        (alu_result),
    .carry_out     (carry_out),
    .overflow      (overflow),
    .cond_sel      (cond_sel),
    .cond_polarity (cond_polarity),
    .status        (status),
    .branch_taken  (branch_taken)
  );

  pc_unit u_pc_unit (
    .clk          (clk),
    .reset        (reset),
    .op_valid     (op_valid),
    .branch_taken (branch_taken),
    .imm          (imm),
    .pc           (pc)
  );

  // result of the last valid op, CMP included even though it writes no register
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
    end else if (op_valid) begin
      result <= alu_result;
    end
  end

endmodule

/* logic/pc_unit.sv */
// 16-bit program counter, one step per valid op
// a taken branch adds 1 plus the sign-extended 8-bit offset
// the sum wraps modulo 2^16

`timescale 1ns/1ps

`include "dp_defines.svh"

module pc_unit (
  input  logic              clk,
  input  logic              reset,
  input  logic              op_valid,
  input  logic              branch_taken,
  input  dp_ops_pkg::data_t imm,
  output dp_ops_pkg::pc_t   pc
);

  localparam int EXT_BITS = `DP_PC_WIDTH - `DP_DATA_WIDTH;
  localparam dp_ops_pkg::pc_t PC_STEP = 1;

  dp_ops_pkg::pc_t offset;
  dp_ops_pkg::pc_t pc_next;

  // offset is relative to the next sequential pc
  assign offset = branch_taken ? {{EXT_BITS{imm[`DP_DATA_WIDTH-1]}}, imm} : '0;
  assign pc_next = pc + offset + PC_STEP;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (op_valid) begin
      pc <= pc_next;
    end
  end

endmodule

/* logic/status_flags.sv */
// N V Z C status register with per-operation update rules
// branch_taken looks at the stored flags, i.e. before this op's own update
// branch_taken is only high for BRA and is not qualified by op_valid

`timescale 1ns/1ps

module status_flags (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    op_valid,
  input  dp_ops_pkg::alu_op_t     alu_op,
  input  dp_ops_pkg::data_t       result,
  input  logic                    carry_out,
  input  logic                    overflow,
  input  dp_flags_pkg::flag_idx_t cond_sel,
  input  logic                    cond_polarity,
  output dp_flags_pkg::status_t   status,
  output logic                    branch_taken
);

  dp_flags_pkg::status_t status_d;
  logic res_zero;
  logic res_neg;

  assign res_zero = (result == '0);
  assign res_neg = result[$bits(result)-1];

  always_comb begin
    status_d = status;
    case (alu_op)
      dp_ops_pkg::ADC, dp_ops_pkg::SBC, dp_ops_pkg::CMP: begin
        status_d[dp_flags_pkg::FLAG_N] = res_neg;
        status_d[dp_flags_pkg::FLAG_Z] = res_zero;
        status_d[dp_flags_pkg::FLAG_C] = carry_out;
        status_d[dp_flags_pkg::FLAG_V] = overflow;
      end
      dp_ops_pkg::ASL, dp_ops_pkg::LSR, dp_ops_pkg::ROL, dp_ops_pkg::ROR: begin
        status_d[dp_flags_pkg::FLAG_N] = res_neg;
        status_d[dp_flags_pkg::FLAG_Z] = res_zero;
        status_d[dp_flags_pkg::FLAG_C] = carry_out;
      end
      dp_ops_pkg::AND, dp_ops_pkg::ORA, dp_ops_pkg::EOR,
      dp_ops_pkg::INC, dp_ops_pkg::DEC, dp_ops_pkg::MOV: begin
        status_d[dp_flags_pkg::FLAG_N] = res_neg;
        status_d[dp_flags_pkg::FLAG_Z] = res_zero;
      end
      dp_ops_pkg::CLC: status_d[dp_flags_pkg::FLAG_C] = 1'b0;
      dp_ops_pkg::SEC: status_d[dp_flags_pkg::FLAG_C] = 1'b1;
      // BRA leaves every flag alone
      default: status_d = status;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      status <= '0;
    end else if (op_valid) begin
      status <= status_d;
    end
  end

  // taken when the selected stored flag differs from cond_polarity
  assign branch_taken = (alu_op == dp_ops_pkg::BRA) && (status[cond_sel] ^ cond_polarity);

endmodule

/* logic/alu.sv */
// 8-bit ALU built around one adder with carry
// SBC and CMP add the inverted operand, CMP forces carry in to 1, DEC adds all ones
// CLC, SEC and BRA pass operand a through as their result

`timescale 1ns/1ps

`include "dp_defines.svh"

module alu (
  input  dp_ops_pkg::alu_op_t alu_op,
  input  dp_ops_pkg::data_t   a,
  input  dp_ops_pkg::data_t   reg_b,
  input  dp_ops_pkg::data_t   imm,
  input  logic                use_imm,
  input  logic                carry_in,
  output dp_ops_pkg::data_t   result,
  output logic                carry_out,
  output logic                overflow,
  output logic                writes_reg
);

  localparam int MSB = `DP_DATA_WIDTH - 1;

  dp_ops_pkg::data_t b;
  dp_ops_pkg::data_t add_b;
  logic add_cin;
  logic [`DP_DATA_WIDTH:0] add_sum;

  // second operand from a register or the immediate
  assign b = use_imm ? imm : reg_b;

  // adder operand setup
  always_comb begin
    add_b = b;
    add_cin = carry_in;
    case (alu_op)
      dp_ops_pkg::SBC: add_b = ~b;
      dp_ops_pkg::CMP: begin
        add_b = ~b;
        add_cin = 1'b1;
      end
      dp_ops_pkg::INC: begin
        add_b = '0;
        add_cin = 1'b1;
      end
      dp_ops_pkg::DEC: begin
        add_b = '1;
        add_cin = 1'b0;
      end
      default: begin
        add_b = b;
        add_cin = carry_in;
      end
    endcase
  end

  assign add_sum = {1'b0, a} + {1'b0, add_b} + add_cin;

  // signed overflow when both addends share a sign the sum does not
  assign overflow = (a[MSB] == add_b[MSB]) && (add_sum[MSB] != a[MSB]);

  always_comb begin
    result = add_sum[MSB:0];
    carry_out = add_sum[`DP_DATA_WIDTH];
    case (alu_op)
      dp_ops_pkg::AND: result = a & b;
      dp_ops_pkg::ORA: result = a | b;
      dp_ops_pkg::EOR: result = a ^ b;
      dp_ops_pkg::ASL: begin
        result = {a[MSB-1:0], 1'b0};
        carry_out = a[MSB];
      end
      dp_ops_pkg::LSR: begin
        result = {1'b0, a[MSB:1]};
        carry_out = a[0];
      end
      // rotates go through the C flag
      dp_ops_pkg::ROL: begin
        result = {a[MSB-1:0], carry_in};
        carry_out = a[MSB];
      end
      dp_ops_pkg::ROR: begin
        result = {carry_in, a[MSB:1]};
        carry_out = a[0];
      end
      dp_ops_pkg::MOV: result = b;
      dp_ops_pkg::CLC, dp_ops_pkg::SEC, dp_ops_pkg::BRA: result = a;
      // ADC, SBC, CMP, INC and DEC take the adder output
      default: result = add_sum[MSB:0];
    endcase
  end

  assign writes_reg = !(alu_op == dp_ops_pkg::CMP || alu_op == dp_ops_pkg::CLC ||
                        alu_op == dp_ops_pkg::SEC || alu_op == dp_ops_pkg::BRA);

endmodule

/* logic/reg_file.sv */
// four-entry register file with two combinational read ports
// the write lands on the clock edge, so a read in the same cycle sees the old value
// all registers clear on reset

`timescale 1ns/1ps

`include "dp_defines.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  write_enable,
  input  dp_ops_pkg::reg_addr_t write_addr,
  input  dp_ops_pkg::data_t     write_data,
  input  dp_ops_pkg::reg_addr_t read_addr_a,
  input  dp_ops_pkg::reg_addr_t read_addr_b,
  output dp_ops_pkg::data_t     read_data_a,
  output dp_ops_pkg::data_t     read_data_b
);

  dp_ops_pkg::data_t regs [`DP_REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `DP_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable) begin
      regs[write_addr] <= write_data;
    end
  end

  // read ports are plain muxes on the register array
  assign read_data_a = regs[read_addr_a];
  assign read_data_b = regs[read_addr_b];

endmodule

/* logic/dp_flags_pkg.sv */
// status flag positions and the status word type
// only N V Z C exist; I, D and B flags are not modelled

`include "dp_defines.svh"

package dp_flags_pkg;

  // bit position inside status_t, also used as the branch condition select
  typedef enum logic [`DP_FLAG_IDX_WIDTH-1:0] {
    FLAG_C = 2'd0,
    FLAG_Z = 2'd1,
    FLAG_V = 2'd2,
    FLAG_N = 2'd3
  } flag_idx_t;

  // ordered N V Z C from high bit to low
  typedef logic [`DP_STATUS_WIDTH-1:0] status_t;

endpackage

/* logic/dp_ops_pkg.sv */
// ALU operation encoding and the word types of the datapath slice
// the encoding is 4 bits wide and has no spare codes

`include "dp_defines.svh"

package dp_ops_pkg;

  typedef logic [`DP_DATA_WIDTH-1:0] data_t;
  typedef logic [`DP_REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`DP_PC_WIDTH-1:0] pc_t;

  // micro-operations, roughly following the 6502 mnemonics
  typedef enum logic [3:0] {
    ADC = 4'd0,
    SBC = 4'd1,
    AND = 4'd2,
    ORA = 4'd3,
    EOR = 4'd4,
    ASL = 4'd5,
    LSR = 4'd6,
    ROL = 4'd7,
    ROR = 4'd8,
    INC = 4'd9,
    DEC = 4'd10,
    // MOV copies operand b, so it loads an immediate or copies a register
    MOV = 4'd11,
    // CMP is a subtract that only sets flags
    CMP = 4'd12,
    CLC = 4'd13,
    SEC = 4'd14,
    // relative branch on the flag picked by cond_sel
    BRA = 4'd15
  } alu_op_t;

endpackage

/* logic/dp_defines.svh */
// width and size macros shared by the datapath packages and modules
// DP_REG_ADDR_WIDTH must stay equal to clog2(DP_REG_COUNT)
// DP_DATA_WIDTH must be at most DP_PC_WIDTH for the relative branch offset

`ifndef DP_DEFINES_SVH
`define DP_DEFINES_SVH

// data word and program counter
`define DP_DATA_WIDTH 8
`define DP_PC_WIDTH 16

// register file geometry
`define DP_REG_COUNT 4
`define DP_REG_ADDR_WIDTH 2

// status word, one bit per flag, and the flag bit position width
`define DP_STATUS_WIDTH 4
`define DP_FLAG_IDX_WIDTH 2

`endif
